// ==== Makefile ====
TOOL   = verilator
FLAGS  = --binary --timing --assert
TOP    = tb_cpu51
FLIST  = cpu51.f
OBJDIR = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJDIR) -o $(TOP)
	@out="$$(./$(OBJDIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test OK$$"

clean:
	rm -rf $(OBJDIR)

// ==== common/cpu51_cfg.svh ====
`ifndef CPU51_CFG_SVH
`define CPU51_CFG_SVH

//////////////////////////////
// uart

// clock cycles per bit, kept small for short runs
`define CPU51_BIT_CYCLES 16

//////////////////////////////
// memory map

// program bytes loaded before the core starts
`define CPU51_CODE_DEPTH 512

`define CPU51_TX_DATA_ADDR 16'h0201  // movx @dptr,a sends acc
`define CPU51_TX_STAT_ADDR 16'h0200  // movx a,@dptr returns busy in bit 0

`endif

// ==== common/cpu51_pkg.sv ====
package cpu51_pkg;

   typedef logic [7:0]        byte_t;
   typedef logic [8:0]        code_addr_t;
   typedef logic [15:0]       dptr_t;
   typedef logic [2:0]        reg_idx_t;
   typedef logic signed [7:0] rel_t;

   // register groups carry the rn index in bits 2:0, named by base value
   typedef enum logic [7:0] {
      OP_NOP      = 8'h00,
      OP_LJMP     = 8'h02,
      OP_INC_R    = 8'h08,
      OP_DEC_A    = 8'h14,
      OP_ADD_AI   = 8'h24,
      OP_ADD_AR   = 8'h28,
      OP_JZ       = 8'h60,
      OP_JNZ      = 8'h70,
      OP_MOV_AI   = 8'h74,
      OP_MOV_RI   = 8'h78,
      OP_SJMP     = 8'h80,
      OP_MOV_DPTR = 8'h90,
      OP_SUBB_AI  = 8'h94,
      OP_CJNE_RI  = 8'hB8,
      OP_CLR_C    = 8'hC3,
      OP_MOVX_LD  = 8'hE0,
      OP_CLR_A    = 8'hE4,
      OP_MOV_AR   = 8'hE8,
      OP_MOVX_ST  = 8'hF0,
      OP_MOV_RA   = 8'hF8
   } opcode_e;

   typedef enum logic [2:0] {
      S_FETCH,
      S_DECODE0,
      S_DECODE1,
      S_DECODE2,
      S_EXECUTE
   } seq_state_e;

   typedef enum logic [1:0] {
      U_IDLE,
      U_START,
      U_DATA,
      U_STOP
   } uart_state_e;

   function automatic logic is_reg_op(byte_t op);
      byte_t base;
      base = {op[7:3], 3'b000};
      case (base)
         OP_INC_R, OP_ADD_AR, OP_MOV_RI,
         OP_CJNE_RI, OP_MOV_AR, OP_MOV_RA: return 1'b1;
         default:                          return 1'b0;
      endcase
   endfunction

   // instruction length in bytes, unknown opcodes are one byte
   function automatic logic [1:0] op_length(byte_t op);
      byte_t base;
      base = is_reg_op(op) ? {op[7:3], 3'b000} : op;
      case (base)
         OP_LJMP, OP_MOV_DPTR, OP_CJNE_RI:        return 2'd3;
         OP_MOV_AI, OP_MOV_RI, OP_ADD_AI,
         OP_SUBB_AI, OP_SJMP, OP_JZ, OP_JNZ:     return 2'd2;
         default:                                return 2'd1;
      endcase
   endfunction

endpackage

// ==== core/execute_unit.sv ====
`include "cpu51_cfg.svh"

module execute_unit (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_exec,
   input  cpu51_pkg::opcode_e    i_op,
   input  cpu51_pkg::byte_t      i_opnd1,
   input  cpu51_pkg::byte_t      i_opnd2,
   input  cpu51_pkg::code_addr_t i_next_pc,
   input  logic                  i_tx_busy,
   output logic                  o_branch_taken,
   output cpu51_pkg::code_addr_t o_branch_target,
   output logic                  o_tx_start,
   output cpu51_pkg::byte_t      o_tx_data
);
   import cpu51_pkg::*;

   byte_t      acc;
   byte_t      regs [8];
   logic       carry;
   dptr_t      dptr;
   byte_t      op_b;
   byte_t      op_base;
   reg_idx_t   ridx;
   byte_t      rsel;
   rel_t       rel;
   code_addr_t rel_target;
   logic [8:0] sub_wide;

   assign op_b    = byte_t'(i_op);
   assign op_base = is_reg_op(op_b) ? {op_b[7:3], 3'b000} : op_b;  // strip rn
   assign ridx    = op_b[2:0];
   assign rsel    = regs[ridx];

   // cjne keeps its offset in the third byte
   assign rel        = rel_t'((op_base == OP_CJNE_RI) ? i_opnd2 : i_opnd1);
   assign rel_target = i_next_pc + code_addr_t'(rel);  // wraps mod 512

   assign sub_wide = {1'b0, acc} - {1'b0, i_opnd1} - {8'd0, carry};  // bit 8 is borrow

   //////////////////////////////
   // branch decision

   always_comb begin
      o_branch_taken  = 1'b0;
      o_branch_target = rel_target;
      if (i_exec) begin
         case (op_base)
            OP_SJMP:    o_branch_taken = 1'b1;
            OP_JZ:      o_branch_taken = (acc == 8'd0);
            OP_JNZ:     o_branch_taken = (acc != 8'd0);
            OP_CJNE_RI: o_branch_taken = (rsel != i_opnd1);
            OP_LJMP: begin
               o_branch_taken  = 1'b1;
               o_branch_target = {i_opnd1[0], i_opnd2};  // low 9 bits of addr16
            end
            default: ;
         endcase
      end
   end

   //////////////////////////////
   // architectural state

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
         for (int i = 0; i < 8; i++) regs[i] <= '0;
      end else if (i_exec) begin
         case (op_base)
            OP_MOV_AI:   acc <= i_opnd1;
            OP_MOV_RI:   regs[ridx] <= i_opnd1;
            OP_MOV_RA:   regs[ridx] <= acc;
            OP_MOV_AR:   acc <= rsel;
            OP_ADD_AI:   acc <= acc + i_opnd1;
            OP_ADD_AR:   acc <= acc + rsel;
            OP_SUBB_AI: begin
               acc   <= sub_wide[7:0];
               carry <= sub_wide[8];
            end
            OP_INC_R:    regs[ridx] <= rsel + 8'd1;
            OP_DEC_A:    acc <= acc - 8'd1;
            OP_CLR_A:    acc <= '0;
            OP_CLR_C:    carry <= 1'b0;
            OP_CJNE_RI:  carry <= (rsel < i_opnd1);
            OP_MOV_DPTR: dptr <= {i_opnd1, i_opnd2};  // high byte first
            OP_MOVX_LD: begin
               if (dptr == `CPU51_TX_STAT_ADDR) acc <= {7'd0, i_tx_busy};
            end
            default: ;  // everything else is a nop
         endcase
      end
   end

   // transmit request, one cycle with the exec strobe
   assign o_tx_start = i_exec && (op_base == OP_MOVX_ST) && (dptr == `CPU51_TX_DATA_ADDR);
   assign o_tx_data  = acc;

endmodule

// ==== core/fetch_decode.sv ====
module fetch_decode (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_load_done,
   input  cpu51_pkg::byte_t      i_code_data,
   input  logic                  i_branch_taken,
   input  cpu51_pkg::code_addr_t i_branch_target,
   output cpu51_pkg::code_addr_t o_code_addr,
   output cpu51_pkg::opcode_e    o_op,
   output cpu51_pkg::byte_t      o_opnd1,
   output cpu51_pkg::byte_t      o_opnd2,
   output logic                  o_exec,
   output cpu51_pkg::code_addr_t o_next_pc
);
   import cpu51_pkg::*;

   seq_state_e state;
   code_addr_t pc;
   logic [1:0] len_new;
   logic [1:0] len_held;

   // opcode arrives in decode0, afterwards it sits in o_op
   assign len_new  = op_length(i_code_data);
   assign len_held = op_length(byte_t'(o_op));

   //////////////////////////////
   // sequencer

   // pc steps once per byte, so it ends on the next instruction
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= S_FETCH;
         pc    <= '0;
      end else begin
         case (state)
            S_FETCH: begin
               if (i_load_done) begin  // hold until the program is in
                  state <= S_DECODE0;
                  pc    <= pc + 1'b1;
               end
            end
            S_DECODE0: begin
               if (len_new > 2'd1) begin
                  state <= S_DECODE1;
                  pc    <= pc + 1'b1;
               end else state <= S_EXECUTE;
            end
            S_DECODE1: begin
               if (len_held == 2'd3) begin
                  state <= S_DECODE2;
                  pc    <= pc + 1'b1;
               end else state <= S_EXECUTE;
            end
            S_DECODE2: state <= S_EXECUTE;
            S_EXECUTE: begin
               state <= S_FETCH;
               if (i_branch_taken) pc <= i_branch_target;
            end
            default: state <= S_FETCH;
         endcase
      end
   end

   //////////////////////////////
   // operand latches

   always_ff @(posedge i_clk) begin
      if (state == S_DECODE0) o_op    <= opcode_e'(i_code_data);
      if (state == S_DECODE1) o_opnd1 <= i_code_data;
      if (state == S_DECODE2) o_opnd2 <= i_code_data;
   end

   assign o_code_addr = pc;
   assign o_next_pc   = pc;
   assign o_exec      = (state == S_EXECUTE);

   // load done must stay up once the core runs
   a_exec_after_load : assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_exec |-> i_load_done)
      else $error("fetch_decode: exec before the program was loaded");

endmodule

// ==== cpu51.f ====
+incdir+common
+incdir+sim
common/cpu51_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
logic/code_ram.sv
core/fetch_decode.sv
core/execute_unit.sv
logic/cpu51_top.sv
sim/tb_cpu51.sv

// ==== logic/code_ram.sv ====
`include "cpu51_cfg.svh"

module code_ram (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_wr_en,
   input  cpu51_pkg::code_addr_t i_wr_addr,
   input  cpu51_pkg::byte_t      i_wr_data,
   input  cpu51_pkg::code_addr_t i_rd_addr,
   output cpu51_pkg::byte_t      o_rd_data
);
   import cpu51_pkg::*;

   byte_t mem [`CPU51_CODE_DEPTH];

   always_ff @(posedge i_clk) begin
      if (i_wr_en) mem[i_wr_addr] <= i_wr_data;
   end

   // read data one cycle after the address
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) o_rd_data <= '0;
      else         o_rd_data <= mem[i_rd_addr];
   end

endmodule

// ==== logic/cpu51_top.sv ====
module cpu51_top (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_uart_rx,
   output logic o_uart_tx
);
   import cpu51_pkg::*;

   // loader to code ram
   logic       wr_en;
   code_addr_t wr_addr;
   byte_t      wr_data;
   logic       load_done;

   code_addr_t code_addr;
   byte_t      code_data;

   // sequencer to execute
   opcode_e    op;
   byte_t      opnd1;
   byte_t      opnd2;
   logic       exec;
   code_addr_t next_pc;
   logic       branch_taken;
   code_addr_t branch_target;

   logic       tx_start;
   byte_t      tx_data;
   logic       tx_busy;

   uart_rx u_rx (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_rx        (i_uart_rx),
      .o_wr_en     (wr_en),
      .o_wr_addr   (wr_addr),
      .o_wr_data   (wr_data),
      .o_load_done (load_done)
   );

   code_ram u_ram (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_wr_en   (wr_en),
      .i_wr_addr (wr_addr),
      .i_wr_data (wr_data),
      .i_rd_addr (code_addr),
      .o_rd_data (code_data)
   );

   fetch_decode u_fetch (
      .i_clk           (i_clk),
      .i_nrst          (i_nrst),
      .i_load_done     (load_done),
      .i_code_data     (code_data),
      .i_branch_taken  (branch_taken),
      .i_branch_target (branch_target),
      .o_code_addr     (code_addr),
      .o_op            (op),
      .o_opnd1         (opnd1),
      .o_opnd2         (opnd2),
      .o_exec          (exec),
      .o_next_pc       (next_pc)
   );

   execute_unit u_exec (
      .i_clk           (i_clk),
      .i_nrst          (i_nrst),
      .i_exec          (exec),
      .i_op            (op),
      .i_opnd1         (opnd1),
      .i_opnd2         (opnd2),
      .i_next_pc       (next_pc),
      .i_tx_busy       (tx_busy),
      .o_branch_taken  (branch_taken),
      .o_branch_target (branch_target),
      .o_tx_start      (tx_start),
      .o_tx_data       (tx_data)
   );

   uart_tx u_tx (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_start (tx_start),
      .i_data  (tx_data),
      .o_tx    (o_uart_tx),
      .o_busy  (tx_busy)
   );

endmodule

// ==== sim/tb_isa_model.svh ====
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

//////////////////////////////
// program builder

function automatic logic [31:0] lcg_next();
   seed = seed * 32'd1103515245 + 32'd12345;
   return seed;
endfunction

function automatic byte_t rand_byte();
   return byte_t'(lcg_next() >> 24);  // upper bits mix best
endfunction

task automatic put_instr(input int n, input byte_t b0, input byte_t b1 = 8'h00,
                         input byte_t b2 = 8'h00);
   img[code_addr_t'(wp)] = b0;
   if (n > 1) img[code_addr_t'(wp + 1)] = b1;
   if (n > 2) img[code_addr_t'(wp + 2)] = b2;
   wp = wp + n;
endtask

// offset is the last byte, so the next pc is right behind it
task automatic patch_rel(input int at);
   img[code_addr_t'(at)] = byte_t'(wp - (at + 1));
endtask

// acc parked in r7 while the busy flag is polled
task automatic transmit_acc();
   int top;
   put_instr(1, 8'hFF);  // mov r7,a
   put_instr(3, 8'h90, byte_t'(`CPU51_TX_STAT_ADDR >> 8), byte_t'(`CPU51_TX_STAT_ADDR));
   top = wp;
   put_instr(1, 8'hE0);
   put_instr(2, 8'h70, byte_t'(top - (wp + 2)));  // jnz back to the poll
   put_instr(1, 8'hEF);  // mov a,r7
   put_instr(3, 8'h90, byte_t'(`CPU51_TX_DATA_ADDR >> 8), byte_t'(`CPU51_TX_DATA_ADDR));
   put_instr(1, 8'hF0);
endtask

task automatic mark_path(input byte_t m);
   put_instr(2, 8'h74, m);
   transmit_acc();
endtask

task automatic build_program();
   int at;
   int back;
   int top;
   img = '{default: 8'h00};
   wp  = 0;
   // arithmetic chain, acc out after every step
   put_instr(1, 8'hC3);
   put_instr(2, 8'h74, rand_byte());
   transmit_acc();
   put_instr(2, 8'h24, rand_byte());
   transmit_acc();
   put_instr(2, 8'h94, rand_byte());
   transmit_acc();
   put_instr(1, 8'h0A);  // inc r2
   put_instr(1, 8'h2A);  // add a,r2
   transmit_acc();
   put_instr(2, 8'h94, rand_byte());  // borrow from the last subb
   transmit_acc();
   put_instr(1, 8'h14);
   transmit_acc();
   put_instr(1, 8'hE4);
   transmit_acc();
   // forward sjmp over a wrong marker
   put_instr(2, 8'h80);
   at = wp - 1;
   mark_path(8'hBA);
   patch_rel(at);
   mark_path(8'h11);
   // jz taken on zero
   put_instr(1, 8'hE4);
   put_instr(2, 8'h60);
   at = wp - 1;
   mark_path(8'hBB);
   patch_rel(at);
   mark_path(8'h22);
   // jnz falls through on zero
   put_instr(1, 8'hE4);
   put_instr(2, 8'h70);
   at = wp - 1;
   mark_path(8'h33);
   patch_rel(at);
   put_instr(2, 8'h70);  // acc still 0x33, taken
   at = wp - 1;
   mark_path(8'hBC);
   patch_rel(at);
   put_instr(2, 8'h60);  // jz falls through on non-zero
   at = wp - 1;
   mark_path(8'h44);
   patch_rel(at);
   // hop past the marker, then come back to it
   put_instr(2, 8'h80);
   at   = wp - 1;
   back = wp;
   mark_path(8'h55);
   put_instr(2, 8'h80);
   top = wp - 1;
   patch_rel(at);
   put_instr(2, 8'h80, byte_t'(back - (wp + 2)));
   patch_rel(top);
   put_instr(3, 8'h02, 8'h01, 8'h00);  // ljmp 0x100

   //////////////////////////////
   // upper half
   wp = 256;
   for (int n = 0; n < 7; n++) put_instr(2, {5'b01111, 3'(n)}, rand_byte());
   put_instr(2, 8'h74, rand_byte());
   put_instr(1, 8'hFB);  // mov r3,a
   for (int n = 0; n < 8; n++) begin
      put_instr(1, {5'b11101, 3'(n)});
      transmit_acc();
   end
   put_instr(2, 8'h79, 8'h00);  // r1 counts 0..2
   top = wp;
   put_instr(1, 8'hE9);
   transmit_acc();
   put_instr(1, 8'h09);
   put_instr(3, 8'hB9, 8'h03, byte_t'(top - (wp + 3)));
   for (int k = 0; k < 5; k++) begin  // burst, each send polls busy
      put_instr(2, 8'h74, rand_byte());
      transmit_acc();
   end
   put_instr(2, 8'h80, 8'hFE);  // halt
endtask

//////////////////////////////
// reference model

function automatic void run_model();
   byte_t       acc;
   byte_t       r [8];
   logic        cy;
   logic        new_cy;
   logic [15:0] dptr;
   code_addr_t  pc;
   code_addr_t  npc;
   byte_t       op;
   byte_t       b1;
   byte_t       b2;
   int          len;
   acc  = 8'h00;
   r    = '{default: 8'h00};
   cy   = 1'b0;
   dptr = 16'h0000;
   pc   = 9'd0;
   for (int step = 0; step < 10000; step++) begin
      op = img[pc];
      b1 = img[pc + 9'd1];
      b2 = img[pc + 9'd2];
      if (op == 8'h80 && b1 == 8'hFE) break;  // sjmp to itself
      casez (op)
         8'h02, 8'h90, 8'b10111???:                          len = 3;
         8'h74, 8'h24, 8'h94, 8'h80, 8'h60, 8'h70, 8'b01111???: len = 2;
         default:                                             len = 1;
      endcase
      npc = pc + code_addr_t'(len);
      casez (op)
         8'h74:       acc = b1;
         8'h24:       acc = acc + b1;
         8'h94: begin
            new_cy = ({1'b0, acc} < ({1'b0, b1} + {8'd0, cy}));
            acc    = acc - b1 - {7'd0, cy};
            cy     = new_cy;
         end
         8'h14:       acc = acc - 8'd1;
         8'hE4:       acc = 8'h00;
         8'hC3:       cy = 1'b0;
         8'h80:       npc = npc + {b1[7], b1};
         8'h02:       npc = {b1[0], b2};
         8'h60:       if (acc == 8'h00) npc = npc + {b1[7], b1};
         8'h70:       if (acc != 8'h00) npc = npc + {b1[7], b1};
         8'h90:       dptr = {b1, b2};
         8'hF0:       if (dptr == `CPU51_TX_DATA_ADDR) exp_q.push_back(acc);
         8'hE0:       if (dptr == `CPU51_TX_STAT_ADDR) acc = 8'h00;  // idle transmitter
         8'b00001???: r[op[2:0]] = r[op[2:0]] + 8'd1;
         8'b00101???: acc = acc + r[op[2:0]];
         8'b01111???: r[op[2:0]] = b1;
         8'b10111???: begin
            cy = (r[op[2:0]] < b1);
            if (r[op[2:0]] != b1) npc = npc + {b2[7], b2};
         end
         8'b11101???: acc = r[op[2:0]];
         8'b11111???: r[op[2:0]] = acc;
         default: ;
      endcase
      pc = npc;
   end
endfunction

`endif

// ==== sim/tb_cpu51.sv ====
`include "cpu51_cfg.svh"

module tb_cpu51;
   import cpu51_pkg::*;

   localparam int BIT_T = `CPU51_BIT_CYCLES * 20;  // time units per uart bit

   logic        clk;
   logic        nrst;
   logic        uart_rx;
   logic        uart_tx;
   logic        loaded;
   byte_t       img [`CPU51_CODE_DEPTH];
   int          wp;
   logic [31:0] seed;
   byte_t       exp_q [$];
   byte_t       rx_q [$];
   int          errors;
   int          n_checked;

   `include "tb_isa_model.svh"

   cpu51_top u_dut (
      .i_clk     (clk),
      .i_nrst    (nrst),
      .i_uart_rx (uart_rx),
      .o_uart_tx (uart_tx)
   );

   initial begin
      clk = 1'b1;
      forever #10 clk = ~clk;
   end

   task automatic drive_frame(input byte_t b);
      uart_rx = 1'b0;
      repeat (`CPU51_BIT_CYCLES) @(negedge clk);
      for (int k = 0; k < 8; k++) begin
         uart_rx = b[0];  // lsb first
         b       = {1'b0, b[7:1]};
         repeat (`CPU51_BIT_CYCLES) @(negedge clk);
      end
      uart_rx = 1'b1;
      repeat (`CPU51_BIT_CYCLES) @(negedge clk);
   endtask

   task automatic finish_run();
      $display("errors: %0d, bytes received: %0d, bytes expected: %0d",
               errors, n_checked, exp_q.size());
      if (errors == 0 && n_checked == exp_q.size()) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   endtask

   task automatic watchdog();
      longint limit;
      // every frame loaded or sent plus slack, then 20% margin
      limit = (longint'(`CPU51_CODE_DEPTH) + longint'(exp_q.size()) + 8)
              * 10 * `CPU51_BIT_CYCLES * 20 * 12 / 10;
      #(limit);
      $display("timeout, transmitter went silent");
      errors++;
      finish_run();
   endtask

   //////////////////////////////
   // stimulus

   initial begin
      nrst      = 1'b1;
      uart_rx   = 1'b1;
      loaded    = 1'b0;
      errors    = 0;
      n_checked = 0;
      seed      = 32'h1993;
      build_program();
      run_model();
      fork
         watchdog();
      join_none
      @(negedge clk);
      nrst = 1'b0;
      repeat (8) @(negedge clk);
      nrst = 1'b1;
      for (int i = 0; i < `CPU51_CODE_DEPTH; i++) drive_frame(img[i]);
      loaded = 1'b1;
      while (n_checked < exp_q.size()) @(negedge clk);
      repeat (30 * `CPU51_BIT_CYCLES) @(negedge clk);  // quiet line, catches extra frames
      finish_run();
   end

   //////////////////////////////
   // line monitor and checks

   initial begin : idle_check
      @(negedge nrst);
      forever begin
         @(negedge clk);
         if (!loaded && uart_tx !== 1'b1) begin
            $display("transmit line left idle during reset or loading at %0t", $time);
            errors++;
         end
      end
   end

   initial begin : uart_monitor
      byte_t b;
      forever begin
         @(negedge uart_tx);
         #(BIT_T / 2);
         if (uart_tx !== 1'b0) begin
            $display("start bit not low at mid-bit, %0t", $time);
            errors++;
         end
         for (int k = 0; k < 8; k++) begin
            #(BIT_T);
            b = {uart_tx, b[7:1]};
         end
         #(BIT_T);
         if (uart_tx !== 1'b1) begin
            $display("stop bit missing at %0t", $time);
            errors++;
         end
         rx_q.push_back(b);
      end
   end

   initial begin : compare
      byte_t b;
      forever begin
         @(negedge clk);
         if (rx_q.size() != 0) begin
            b = rx_q.pop_front();
            if (n_checked >= exp_q.size()) begin
               $display("extra byte %h received beyond the %0d expected", b, exp_q.size());
               errors++;
            end else if (b !== exp_q[n_checked]) begin
               $display("CHECK FAILED at %0t: byte %0d expected %h, received %h",
                        $time, n_checked, exp_q[n_checked], b);
               errors++;
            end
            n_checked++;
         end
      end
   end

endmodule

// ==== uart/uart_rx.sv ====
`include "cpu51_cfg.svh"

module uart_rx (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_rx,
   output logic                  o_wr_en,
   output cpu51_pkg::code_addr_t o_wr_addr,
   output cpu51_pkg::byte_t      o_wr_data,
   output logic                  o_load_done
);
   import cpu51_pkg::*;

   localparam int CNT_W = $clog2(`CPU51_BIT_CYCLES);
   // start wait shortened by the sync and detect latency
   localparam int HALF_WAIT = `CPU51_BIT_CYCLES / 2 - 4;

   logic [1:0]       rx_sync;
   logic             rx_s;
   uart_state_e      state;
   logic [CNT_W-1:0] cnt;
   logic [2:0]       bit_idx;
   byte_t            shreg;
   code_addr_t       byte_cnt;
   logic             half_hit;
   logic             full_hit;
   logic             frame_ok;

   assign rx_s     = rx_sync[1];
   assign half_hit = (cnt == CNT_W'(HALF_WAIT));
   assign full_hit = (cnt == CNT_W'(`CPU51_BIT_CYCLES - 1));
   assign frame_ok = (state == U_STOP) && full_hit && rx_s;  // stop bit must be high

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) rx_sync <= 2'b11;  // idle line
      else         rx_sync <= {rx_sync[0], i_rx};
   end

   //////////////////////////////
   // frame fsm

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= U_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
      end else begin
         case (state)
            U_IDLE: begin
               cnt <= '0;
               if (!rx_s) state <= U_START;
            end
            U_START: begin
               if (half_hit) begin
                  cnt     <= '0;
                  bit_idx <= '0;
                  state   <= rx_s ? U_IDLE : U_DATA;  // glitch, not a start bit
               end else cnt <= cnt + 1'b1;
            end
            U_DATA: begin
               if (full_hit) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) state <= U_STOP;
               end else cnt <= cnt + 1'b1;
            end
            default: begin
               if (full_hit) begin
                  cnt   <= '0;
                  state <= U_IDLE;
               end else cnt <= cnt + 1'b1;
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == U_DATA && full_hit) shreg <= {rx_s, shreg[7:1]};  // lsb first
   end

   //////////////////////////////
   // program load

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_wr_en     <= 1'b0;
         byte_cnt    <= '0;
         o_load_done <= 1'b0;
      end else begin
         o_wr_en <= frame_ok && !o_load_done;
         if (o_wr_en) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == code_addr_t'(`CPU51_CODE_DEPTH - 1)) o_load_done <= 1'b1;
         end
      end
   end

   assign o_wr_addr = byte_cnt;
   assign o_wr_data = shreg;

   a_no_write_after_load : assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_load_done |-> !o_wr_en)
      else $error("uart_rx: code write after load done");

endmodule

// ==== uart/uart_tx.sv ====
`include "cpu51_cfg.svh"

module uart_tx (
   input  logic             i_clk,
   input  logic             i_nrst,
   input  logic             i_start,
   input  cpu51_pkg::byte_t i_data,
   output logic             o_tx,
   output logic             o_busy
);
   import cpu51_pkg::*;

   localparam int CNT_W = $clog2(`CPU51_BIT_CYCLES);

   uart_state_e      state;
   logic [CNT_W-1:0] cnt;
   logic [2:0]       bit_idx;
   byte_t            shreg;
   logic             bit_end;

   assign bit_end = (cnt == CNT_W'(`CPU51_BIT_CYCLES - 1));
   assign o_busy  = (state != U_IDLE);  // drops after the stop bit

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= U_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
         o_tx    <= 1'b1;
      end else begin
         if (state == U_IDLE || bit_end) cnt <= '0;
         else                            cnt <= cnt + 1'b1;

         case (state)
            U_IDLE: begin
               if (i_start) begin
                  state <= U_START;
                  o_tx  <= 1'b0;
               end
            end
            U_START: begin
               if (bit_end) begin
                  state   <= U_DATA;
                  bit_idx <= '0;
                  o_tx    <= shreg[0];
               end
            end
            U_DATA: begin
               if (bit_end) begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= U_STOP;
                     o_tx  <= 1'b1;
                  end else o_tx <= shreg[1];  // next bit, shreg shifts now
               end
            end
            default: begin
               if (bit_end) state <= U_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == U_IDLE && i_start)    shreg <= i_data;
      else if (state == U_DATA && bit_end) shreg <= shreg >> 1;
   end

   // core must poll busy before each send
   a_start_when_idle : assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_start |-> !o_busy)
      else $error("uart_tx: start while busy, byte dropped");

endmodule
